//--- issue_buffer.f
+incdir+hw
+incdir+testbench
hw/ib_pkg.sv
hw/ib_dispatch_steer.sv
hw/ib_inst_queue.sv
hw/ib_issue_port.sv
hw/issue_buffer_top.sv
testbench/tb_issue_buffer.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_issue_buffer -Mdir obj_dir -f issue_buffer.f
	./obj_dir/Vtb_issue_buffer | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_issue_buffer_tasks.svh
// --------------------------------------------------
// Failure reporting and typed compares
// --------------------------------------------------
task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic compare_tag(input ib_tag_t exp_val, input ib_tag_t act_val);
    if (act_val !== exp_val) begin
        $display("[ERROR] %s: tag expected 0x%0h, actual 0x%0h", test_name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic compare_thread(input ib_thread_t exp_val, input ib_thread_t act_val);
    if (act_val !== exp_val) begin
        $display("[ERROR] %s: thread expected %0d, actual %0d", test_name, exp_val, act_val);
        abort_run();
    end
endtask

task automatic compare_count(input int exp_val, input int act_val);
    if (act_val != exp_val) begin
        $display("[ERROR] %s: count expected %0d, actual %0d", test_name, exp_val, act_val);
        abort_run();
    end
endtask

// --------------------------------------------------
// Reference model
// --------------------------------------------------
task automatic model_push(input ib_class_e cls, input ib_thread_t thr, input ib_tag_t tag);
    exp_thread[int'(cls)].push_back(thr);
    exp_tag[int'(cls)].push_back(tag);
endtask

// Issued item must be the oldest of its class
task automatic check_issue(input int c, input int p, input ib_thread_t thr, input ib_tag_t tag);
    if (exp_tag[c].size() == 0) begin
        $display("%s: class %0d port %0d issued an instruction that was never dispatched",
                 test_name, c, p);
        abort_run();
    end
    compare_tag(exp_tag[c][0], tag);
    compare_thread(exp_thread[c][0], thr);
    void'(exp_tag[c].pop_front());
    void'(exp_thread[c].pop_front());
endtask

task automatic model_clear();
    for (int c = 0; c < `IB_CLASS_NUM; c++) begin
        exp_tag[c].delete();
        exp_thread[c].delete();
    end
endtask

task automatic model_drop_thread(input ib_thread_t thr);
    ib_thread_t keep_thr[$];
    ib_tag_t    keep_tag[$];

    for (int c = 0; c < `IB_CLASS_NUM; c++) begin
        keep_thr.delete();
        keep_tag.delete();
        for (int i = 0; i < exp_tag[c].size(); i++) begin
            if (exp_thread[c][i] != thr) begin
                keep_thr.push_back(exp_thread[c][i]);
                keep_tag.push_back(exp_tag[c][i]);
            end
        end
        exp_thread[c] = keep_thr;
        exp_tag[c]    = keep_tag;
    end
endtask

function automatic bit model_empty();
    for (int c = 0; c < `IB_CLASS_NUM; c++) begin
        if (exp_tag[c].size() != 0) begin
            return 1'b0;
        end
    end
    return 1'b1;
endfunction

// --------------------------------------------------
// Stimulus
// --------------------------------------------------
task automatic set_fu_ready(input logic [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] rdy);
    @(posedge clk_i);
    fu_ready_i <= rdy;
endtask

task automatic release_slots();
    @(posedge clk_i);
    disp_valid_i <= '0;
endtask

// Negative class picks one at random per item
task automatic queue_items(input int n, input int cls);
    for (int i = 0; i < n; i++) begin
        if (cls < 0) begin
            pend_cls.push_back(ib_class_e'($urandom_range(`IB_CLASS_NUM - 1)));
        end else begin
            pend_cls.push_back(ib_class_e'(cls));
        end
        pend_thr.push_back(ib_thread_t'($urandom_range(`IB_THREAD_NUM - 1)));
        pend_tag.push_back(ib_tag_t'($urandom));
    end
endtask

// Offers the oldest pending items for one cycle
task automatic dispatch_cycle(output int acc);
    logic       [`IB_DISP_NUM-1:0] v;
    ib_class_e  [`IB_DISP_NUM-1:0] c;
    ib_thread_t [`IB_DISP_NUM-1:0] t;
    ib_tag_t    [`IB_DISP_NUM-1:0] g;

    for (int s = 0; s < `IB_DISP_NUM; s++) begin
        v[s] = 1'b0;
        c[s] = IB_CLASS_ALU;
        t[s] = '0;
        g[s] = '0;
        if (s < pend_cls.size()) begin
            v[s] = 1'b1;
            c[s] = pend_cls[s];
            t[s] = pend_thr[s];
            g[s] = pend_tag[s];
        end
    end
    @(posedge clk_i);
    disp_valid_i  <= v;
    disp_class_i  <= c;
    disp_thread_i <= t;
    disp_tag_i    <= g;
    @(negedge clk_i);
    // Ready is contiguous, so accepted slots form a prefix
    acc = 0;
    for (int s = 0; s < `IB_DISP_NUM; s++) begin
        if (v[s] && disp_ready_o[s]) begin
            model_push(c[s], t[s], g[s]);
            acc++;
        end
    end
    for (int i = 0; i < acc; i++) begin
        void'(pend_cls.pop_front());
        void'(pend_thr.pop_front());
        void'(pend_tag.pop_front());
    end
endtask

task automatic send_stream(input int n, input int cls);
    int acc;
    int stall;

    queue_items(n, cls);
    stall = 0;
    while (pend_cls.size() > 0) begin
        dispatch_cycle(acc);
        stall = (acc == 0) ? stall + 1 : 0;
        if (stall > STALL_LIMIT) begin
            $display("%s: dispatch accepted nothing for %0d cycles", test_name, STALL_LIMIT);
            abort_run();
        end
    end
    release_slots();
endtask

// Keeps both slots busy until dispatch stalls
task automatic fill_until_stall(input ib_class_e cls, output int total);
    int acc;
    int cycles;

    queue_items(4 * `IB_Q_SIZE, int'(cls));
    total  = 0;
    cycles = 0;
    acc    = 1;
    while (acc != 0) begin
        dispatch_cycle(acc);
        total += acc;
        cycles++;
        if (cycles > STALL_LIMIT) begin
            $display("%s: disp_ready_o never dropped under back-pressure", test_name);
            abort_run();
        end
    end
    pend_cls.delete();
    pend_thr.delete();
    pend_tag.delete();
    release_slots();
endtask

// --------------------------------------------------
// Waits
// --------------------------------------------------
task automatic wait_drain();
    int cycles;

    cycles = 0;
    while (!model_empty()) begin
        @(posedge clk_i);
        cycles++;
        if (cycles > DRAIN_LIMIT) begin
            $display("%s: expected instructions never issued within %0d cycles",
                     test_name, DRAIN_LIMIT);
            abort_run();
        end
    end
endtask

// No port may show valid over the window
task automatic check_quiet(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge clk_i);
        compare_count(0, $countones(fu_valid_o));
    end
endtask

//--- testbench/tb_issue_buffer.sv
`include "ib_defines.svh"

module tb_issue_buffer
    import ib_pkg::*;
();

    // Bounds for wait loops, in cycles
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 500;

    logic clk_i = 1'b0;
    logic rst_i;

    logic       [`IB_DISP_NUM-1:0]                     disp_valid_i;
    ib_thread_t [`IB_DISP_NUM-1:0]                     disp_thread_i;
    ib_class_e  [`IB_DISP_NUM-1:0]                     disp_class_i;
    ib_tag_t    [`IB_DISP_NUM-1:0]                     disp_tag_i;
    logic       [`IB_DISP_NUM-1:0]                     disp_ready_o;
    ib_thread_mask_t                                   br_mis_i;
    logic                                              exception_i;
    logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] fu_valid_o;
    logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] fu_ready_i;
    ib_thread_t [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] fu_thread_o;
    ib_tag_t    [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] fu_tag_o;

    // Reference model, one FIFO per class
    ib_thread_t exp_thread [`IB_CLASS_NUM][$];
    ib_tag_t    exp_tag    [`IB_CLASS_NUM][$];

    // Items waiting to be dispatched, oldest first
    ib_class_e  pend_cls[$];
    ib_thread_t pend_thr[$];
    ib_tag_t    pend_tag[$];

    string test_name = "init";

    issue_buffer_top DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .disp_valid_i  (disp_valid_i),
        .disp_thread_i (disp_thread_i),
        .disp_class_i  (disp_class_i),
        .disp_tag_i    (disp_tag_i),
        .disp_ready_o  (disp_ready_o),
        .br_mis_i      (br_mis_i),
        .exception_i   (exception_i),
        .fu_valid_o    (fu_valid_o),
        .fu_ready_i    (fu_ready_i),
        .fu_thread_o   (fu_thread_o),
        .fu_tag_o      (fu_tag_o)
    );

    always #50 clk_i = ~clk_i;

    `include "tb_issue_buffer_tasks.svh"

    // --------------------------------------------------
    // Output monitor
    // --------------------------------------------------
    // Sampled mid-cycle, the transfer completes at the next edge
    always @(negedge clk_i) begin
        if (!rst_i) begin
            for (int c = 0; c < `IB_CLASS_NUM; c++) begin
                // Port 0 carries the older item
                for (int p = 0; p < `IB_ISSUE_NUM; p++) begin
                    if (fu_valid_o[c][p] && fu_ready_i[c][p]) begin
                        check_issue(c, p, fu_thread_o[c][p], fu_tag_o[c][p]);
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_reset_state();
        test_name = "reset_state";
        @(negedge clk_i);
        compare_count(0, $countones(fu_valid_o));
        // Empty queues accept every slot
        compare_count((1 << `IB_DISP_NUM) - 1, int'(disp_ready_o));
    endtask

    task automatic test_load_stream();
        test_name = "load_stream";
        set_fu_ready('1);
        send_stream(40, int'(IB_CLASS_LOAD));
        wait_drain();
    endtask

    task automatic test_mixed_classes();
        test_name = "mixed_classes";
        set_fu_ready('1);
        send_stream(60, -1);
        wait_drain();
    endtask

    task automatic test_back_pressure();
        logic [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] rdy;
        int                                          total;

        test_name = "back_pressure";
        rdy = '1;
        rdy[IB_CLASS_LOAD] = '0;
        set_fu_ready(rdy);
        fill_until_stall(IB_CLASS_LOAD, total);
        // Queue depth plus both port registers
        compare_count(`IB_Q_SIZE + `IB_ISSUE_NUM, total);
        set_fu_ready('1);
        wait_drain();
    endtask

    task automatic test_branch_mispredict();
        test_name = "branch_mispredict";
        set_fu_ready('0);
        send_stream(9, -1);
        @(posedge clk_i);
        br_mis_i <= 2'b10;
        // Thread 1 never issues from here on
        model_drop_thread(1'b1);
        @(posedge clk_i);
        br_mis_i   <= '0;
        fu_ready_i <= '1;
        wait_drain();
    endtask

    task automatic test_exception();
        test_name = "exception";
        set_fu_ready('0);
        send_stream(9, -1);
        @(posedge clk_i);
        exception_i <= 1'b1;
        model_clear();
        @(posedge clk_i);
        exception_i <= 1'b0;
        fu_ready_i  <= '1;
        check_quiet(4);
        // Fresh traffic after the flush
        send_stream(60, -1);
        wait_drain();
    endtask

    initial begin
        void'($urandom(6604));
        rst_i         = 1'b1;
        disp_valid_i  = '0;
        disp_thread_i = '0;
        disp_tag_i    = '0;
        for (int s = 0; s < `IB_DISP_NUM; s++) begin
            disp_class_i[s] = IB_CLASS_ALU;
        end
        br_mis_i      = '0;
        exception_i   = 1'b0;
        fu_ready_i    = '1;

        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        test_reset_state();
        test_load_stream();
        test_mixed_classes();
        test_back_pressure();
        test_branch_mispredict();
        test_exception();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- hw/issue_buffer_top.sv
`include "ib_defines.svh"

module issue_buffer_top
    import ib_pkg::*;
(
    input  logic                                               clk_i,
    input  logic                                               rst_i,
    // Dispatch
    input  logic       [`IB_DISP_NUM-1:0]                      disp_valid_i,
    input  ib_thread_t [`IB_DISP_NUM-1:0]                      disp_thread_i,
    input  ib_class_e  [`IB_DISP_NUM-1:0]                      disp_class_i,
    input  ib_tag_t    [`IB_DISP_NUM-1:0]                      disp_tag_i,
    output logic       [`IB_DISP_NUM-1:0]                      disp_ready_o,
    // Flush
    input  ib_thread_mask_t                                    br_mis_i,
    input  logic                                               exception_i,
    // Function unit ports, class outer, port inner
    output logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0]  fu_valid_o,
    input  logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0]  fu_ready_i,
    output ib_thread_t [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0]  fu_thread_o,
    output ib_tag_t    [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0]  fu_tag_o
);

    // Steer to queues
    logic       [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  push_valid;
    logic       [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  push_ready;
    ib_thread_t [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  push_thread;
    ib_tag_t    [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  push_tag;

    // Queues to issue ports
    logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] pop_valid;
    logic       [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] pop_ready;
    ib_thread_t [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] pop_thread;
    ib_tag_t    [`IB_CLASS_NUM-1:0][`IB_ISSUE_NUM-1:0] pop_tag;

    ib_dispatch_steer u_steer (
        .disp_valid_i    (disp_valid_i),
        .disp_thread_i   (disp_thread_i),
        .disp_class_i    (disp_class_i),
        .disp_tag_i      (disp_tag_i),
        .disp_ready_o    (disp_ready_o),
        .q_push_valid_o  (push_valid),
        .q_push_thread_o (push_thread),
        .q_push_tag_o    (push_tag),
        .q_push_ready_i  (push_ready)
    );

    // --------------------------------------------------
    // One queue and one port set per class
    // --------------------------------------------------
    for (genvar c = 0; c < `IB_CLASS_NUM; c++) begin : g_class
        ib_inst_queue #(
            .C_SIZE (`IB_Q_SIZE)
        ) u_queue (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .s_valid_i   (push_valid[c]),
            .s_ready_o   (push_ready[c]),
            .s_thread_i  (push_thread[c]),
            .s_tag_i     (push_tag[c]),
            .m_valid_o   (pop_valid[c]),
            .m_ready_i   (pop_ready[c]),
            .m_thread_o  (pop_thread[c]),
            .m_tag_o     (pop_tag[c]),
            .br_mis_i    (br_mis_i),
            .exception_i (exception_i)
        );

        ib_issue_port u_port (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .pop_valid_i  (pop_valid[c]),
            .pop_thread_i (pop_thread[c]),
            .pop_tag_i    (pop_tag[c]),
            .pop_ready_o  (pop_ready[c]),
            .fu_valid_o   (fu_valid_o[c]),
            .fu_thread_o  (fu_thread_o[c]),
            .fu_tag_o     (fu_tag_o[c]),
            .fu_ready_i   (fu_ready_i[c]),
            .br_mis_i     (br_mis_i),
            .exception_i  (exception_i)
        );
    end

endmodule

//--- hw/ib_issue_port.sv
`include "ib_defines.svh"

module ib_issue_port
    import ib_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_i,
    // From queue pop lanes
    input  logic       [`IB_ISSUE_NUM-1:0]    pop_valid_i,
    input  ib_thread_t [`IB_ISSUE_NUM-1:0]    pop_thread_i,
    input  ib_tag_t    [`IB_ISSUE_NUM-1:0]    pop_tag_i,
    output logic       [`IB_ISSUE_NUM-1:0]    pop_ready_o,
    // To function units
    output logic       [`IB_ISSUE_NUM-1:0]    fu_valid_o,
    output ib_thread_t [`IB_ISSUE_NUM-1:0]    fu_thread_o,
    output ib_tag_t    [`IB_ISSUE_NUM-1:0]    fu_tag_o,
    input  logic       [`IB_ISSUE_NUM-1:0]    fu_ready_i,
    // Flush
    input  ib_thread_mask_t                   br_mis_i,
    input  logic                              exception_i
);

    logic       [`IB_ISSUE_NUM-1:0] slot_valid;
    ib_thread_t [`IB_ISSUE_NUM-1:0] slot_thread;
    ib_tag_t    [`IB_ISSUE_NUM-1:0] slot_tag;

    // Per port: being squashed, free at the edge, loading
    logic [`IB_ISSUE_NUM-1:0] kill;
    logic [`IB_ISSUE_NUM-1:0] free;
    logic [`IB_ISSUE_NUM-1:0] load;

    // --------------------------------------------------
    // Port status and ready
    // --------------------------------------------------
    always_comb begin
        logic upper_free;

        for (int j = 0; j < `IB_ISSUE_NUM; j++) begin
            kill[j]       = slot_valid[j] && br_mis_i[slot_thread[j]];
            // Hidden already in the flag cycle
            fu_valid_o[j] = slot_valid[j] && !kill[j] && !exception_i;
            // Empty, draining or squashed
            free[j]       = !slot_valid[j] || fu_ready_i[j] || kill[j];
        end

        // Port j also waits for the ports above it
        // so a lower port never holds a younger item
        upper_free = 1'b1;
        for (int j = `IB_ISSUE_NUM - 1; j >= 0; j--) begin
            pop_ready_o[j] = free[j] && upper_free;
            upper_free     = upper_free && free[j];
        end
    end

    assign load = pop_valid_i & pop_ready_o;

    // --------------------------------------------------
    // Issue registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            slot_valid <= '0;
        end else begin
            for (int j = 0; j < `IB_ISSUE_NUM; j++) begin
                if (load[j]) begin
                    slot_valid[j] <= 1'b1;
                end else if (free[j]) begin
                    slot_valid[j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int j = 0; j < `IB_ISSUE_NUM; j++) begin
            if (load[j]) begin
                slot_thread[j] <= pop_thread_i[j];
                slot_tag[j]    <= pop_tag_i[j];
            end
        end
    end

    assign fu_thread_o = slot_thread;
    assign fu_tag_o    = slot_tag;

endmodule

//--- hw/ib_inst_queue.sv
`include "ib_defines.svh"

module ib_inst_queue
    import ib_pkg::*;
#(
    parameter int unsigned C_SIZE = `IB_Q_SIZE
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // Push lanes
    input  logic       [`IB_DISP_NUM-1:0]     s_valid_i,
    output logic       [`IB_DISP_NUM-1:0]     s_ready_o,
    input  ib_thread_t [`IB_DISP_NUM-1:0]     s_thread_i,
    input  ib_tag_t    [`IB_DISP_NUM-1:0]     s_tag_i,
    // Pop lanes, lane 0 at the head
    output logic       [`IB_ISSUE_NUM-1:0]    m_valid_o,
    input  logic       [`IB_ISSUE_NUM-1:0]    m_ready_i,
    output ib_thread_t [`IB_ISSUE_NUM-1:0]    m_thread_o,
    output ib_tag_t    [`IB_ISSUE_NUM-1:0]    m_tag_o,
    // Flush
    input  ib_thread_mask_t                   br_mis_i,
    input  logic                              exception_i
);

    localparam int unsigned C_IN_NUM    = `IB_DISP_NUM;
    localparam int unsigned C_OUT_NUM   = `IB_ISSUE_NUM;
    localparam int unsigned C_IDX_WIDTH = (C_SIZE > 1) ? $clog2(C_SIZE) : 1;
    localparam int unsigned C_NUM_WIDTH = $clog2(C_SIZE + 1);
    // Pointer plus count stays below 2*C_SIZE
    localparam int unsigned C_SUM_WIDTH = C_NUM_WIDTH + 1;

    // Circular add, result is {wrap, index}
    function automatic logic [C_IDX_WIDTH:0] ptr_add(
        input logic [C_IDX_WIDTH-1:0] ptr,
        input logic [C_NUM_WIDTH-1:0] inc
    );
        logic [C_SUM_WIDTH-1:0] sum;

        sum = C_SUM_WIDTH'(ptr) + C_SUM_WIDTH'(inc);
        if (sum >= C_SUM_WIDTH'(C_SIZE)) begin
            sum = sum - C_SUM_WIDTH'(C_SIZE);
            return {1'b1, sum[C_IDX_WIDTH-1:0]};
        end
        return {1'b0, sum[C_IDX_WIDTH-1:0]};
    endfunction

    // Pointers, wrap bit flips on each rollover
    logic [C_IDX_WIDTH-1:0]                head;
    logic [C_IDX_WIDTH-1:0]                tail;
    logic                                  head_wrap;
    logic                                  tail_wrap;
    logic [C_IDX_WIDTH:0]                  head_step;
    logic [C_IDX_WIDTH:0]                  tail_step;

    // Counts
    logic [C_NUM_WIDTH-1:0]                push_num;
    logic [C_NUM_WIDTH-1:0]                pop_num;
    logic [C_NUM_WIDTH-1:0]                data_num;
    logic [C_NUM_WIDTH-1:0]                free_num;

    // Entries
    logic       [C_SIZE-1:0]               entry_valid;
    ib_thread_t [C_SIZE-1:0]               entry_thread;
    ib_tag_t    [C_SIZE-1:0]               entry_tag;

    // Lane bookkeeping
    logic [C_IN_NUM-1:0]                   push_en;
    logic [C_IN_NUM-1:0][C_IDX_WIDTH-1:0]  push_idx;
    logic [C_OUT_NUM-1:0][C_IDX_WIDTH-1:0] pop_idx;
    logic [C_OUT_NUM-1:0]                  skip;
    logic [C_OUT_NUM-1:0]                  pop_done;
    logic [C_SIZE-1:0]                     pop_sel;

    // --------------------------------------------------
    // Occupancy
    // --------------------------------------------------
    always_comb begin
        if (head_wrap == tail_wrap) begin
            data_num = C_NUM_WIDTH'(tail) - C_NUM_WIDTH'(head);
        end else begin
            data_num = C_NUM_WIDTH'(C_SIZE) - C_NUM_WIDTH'(head) + C_NUM_WIDTH'(tail);
        end
    end

    // Slots leaving this cycle count as free
    assign free_num = C_NUM_WIDTH'(C_SIZE) - data_num + pop_num;

    // --------------------------------------------------
    // Push side
    // --------------------------------------------------
    always_comb begin
        logic [C_IDX_WIDTH:0] pos;

        for (int unsigned i = 0; i < C_IN_NUM; i++) begin
            s_ready_o[i] = C_NUM_WIDTH'(i) < free_num;
            pos          = ptr_add(tail, C_NUM_WIDTH'(i));
            push_idx[i]  = pos[C_IDX_WIDTH-1:0];
        end
    end

    assign push_en = s_valid_i & s_ready_o;

    always_comb begin
        push_num = '0;
        for (int unsigned i = 0; i < C_IN_NUM; i++) begin
            push_num = push_num + C_NUM_WIDTH'(push_en[i]);
        end
    end

    // --------------------------------------------------
    // Pop side with head skip
    // --------------------------------------------------
    always_comb begin
        logic [C_IDX_WIDTH:0] pos;
        logic                 chain;
        logic                 live;

        // Lane j only moves once lane j-1 popped or skipped
        chain   = 1'b1;
        pop_sel = '0;
        for (int unsigned j = 0; j < C_OUT_NUM; j++) begin
            pos           = ptr_add(head, C_NUM_WIDTH'(j));
            pop_idx[j]    = pos[C_IDX_WIDTH-1:0];
            m_thread_o[j] = entry_thread[pop_idx[j]];
            m_tag_o[j]    = entry_tag[pop_idx[j]];

            // Squashed earlier, or flagged right now
            live = entry_valid[pop_idx[j]] && !br_mis_i[entry_thread[pop_idx[j]]];

            m_valid_o[j] = 1'b0;
            skip[j]      = 1'b0;
            if (chain && (C_NUM_WIDTH'(j) < data_num)) begin
                m_valid_o[j] = live;
                // Dead entry at the front is dropped this cycle
                skip[j]      = !live;
            end

            pop_done[j] = (m_valid_o[j] && m_ready_i[j]) || skip[j];
            chain       = pop_done[j];
            if (pop_done[j]) begin
                pop_sel[pop_idx[j]] = 1'b1;
            end
        end
    end

    always_comb begin
        pop_num = '0;
        for (int unsigned j = 0; j < C_OUT_NUM; j++) begin
            pop_num = pop_num + C_NUM_WIDTH'(pop_done[j]);
        end
    end

    // --------------------------------------------------
    // Pointers
    // --------------------------------------------------
    assign head_step = ptr_add(head, pop_num);
    assign tail_step = ptr_add(tail, push_num);

    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            head      <= '0;
            tail      <= '0;
            head_wrap <= 1'b0;
            tail_wrap <= 1'b0;
        end else begin
            head      <= head_step[C_IDX_WIDTH-1:0];
            tail      <= tail_step[C_IDX_WIDTH-1:0];
            head_wrap <= head_wrap ^ head_step[C_IDX_WIDTH];
            tail_wrap <= tail_wrap ^ tail_step[C_IDX_WIDTH];
        end
    end

    // --------------------------------------------------
    // Entries
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            entry_valid <= '0;
        end else begin
            // Popped, skipped or flagged entries drop out
            for (int unsigned e = 0; e < C_SIZE; e++) begin
                if (pop_sel[e] || (entry_valid[e] && br_mis_i[entry_thread[e]])) begin
                    entry_valid[e] <= 1'b0;
                end
            end
            // A push wins over a pop of the same slot
            for (int unsigned i = 0; i < C_IN_NUM; i++) begin
                if (push_en[i]) begin
                    entry_valid[push_idx[i]] <= 1'b1;
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        for (int unsigned i = 0; i < C_IN_NUM; i++) begin
            if (push_en[i]) begin
                entry_thread[push_idx[i]] <= s_thread_i[i];
                entry_tag[push_idx[i]]    <= s_tag_i[i];
            end
        end
    end

endmodule

//--- hw/ib_dispatch_steer.sv
`include "ib_defines.svh"

module ib_dispatch_steer
    import ib_pkg::*;
(
    // Dispatch slots, slot 0 oldest
    input  logic       [`IB_DISP_NUM-1:0]                     disp_valid_i,
    input  ib_thread_t [`IB_DISP_NUM-1:0]                     disp_thread_i,
    input  ib_class_e  [`IB_DISP_NUM-1:0]                     disp_class_i,
    input  ib_tag_t    [`IB_DISP_NUM-1:0]                     disp_tag_i,
    output logic       [`IB_DISP_NUM-1:0]                     disp_ready_o,
    // Push lanes, class outer, lane inner
    output logic       [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  q_push_valid_o,
    output ib_thread_t [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  q_push_thread_o,
    output ib_tag_t    [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  q_push_tag_o,
    input  logic       [`IB_CLASS_NUM-1:0][`IB_DISP_NUM-1:0]  q_push_ready_i
);

    // Lane select width
    localparam int LANE_W = (`IB_DISP_NUM > 1) ? $clog2(`IB_DISP_NUM) : 1;

    // --------------------------------------------------
    // In-order grant and lane routing
    // --------------------------------------------------
    always_comb begin
        logic [LANE_W-1:0]       lane;
        logic [1:0]              cls;
        logic                    older_ok;
        logic [`IB_DISP_NUM-1:0] accept;

        q_push_valid_o  = '0;
        q_push_thread_o = '0;
        q_push_tag_o    = '0;
        disp_ready_o    = '0;
        accept          = '0;
        // Slot 0 has nothing older to wait on
        older_ok        = 1'b1;

        for (int s = 0; s < `IB_DISP_NUM; s++) begin
            cls = disp_class_i[s];

            // Lane = older accepted slots of the same class
            lane = '0;
            for (int o = 0; o < s; o++) begin
                if (accept[o] && (disp_class_i[o] == disp_class_i[s])) begin
                    lane = lane + LANE_W'(1);
                end
            end

            // Needs a free lane in its queue
            // and no stalled valid slot ahead of it
            disp_ready_o[s] = older_ok
                           && (int'(cls) < `IB_CLASS_NUM)
                           && q_push_ready_i[cls][lane];

            accept[s] = disp_valid_i[s] && disp_ready_o[s];

            // Only granted slots reach a lane
            // Lanes of one class fill from 0 with no gap
            if (accept[s]) begin
                q_push_valid_o[cls][lane]  = 1'b1;
                q_push_thread_o[cls][lane] = disp_thread_i[s];
                q_push_tag_o[cls][lane]    = disp_tag_i[s];
            end

            // Idle slot does not block younger ones
            older_ok = older_ok && (accept[s] || !disp_valid_i[s]);
        end
    end

endmodule

//--- hw/ib_pkg.sv
`include "ib_defines.svh"

package ib_pkg;

    // --------------------------------------------------
    // Instruction fields
    // --------------------------------------------------

    // Thread index
    typedef logic [$clog2(`IB_THREAD_NUM)-1:0] ib_thread_t;

    // One flag per thread
    // Bit t set squashes thread t
    typedef logic [`IB_THREAD_NUM-1:0] ib_thread_mask_t;

    // Reorder buffer tag
    typedef logic [`IB_TAG_WIDTH-1:0] ib_tag_t;

    // --------------------------------------------------
    // Execution class
    // --------------------------------------------------

    // Also the queue index
    // Code 3 is unused and never accepted
    typedef enum logic [1:0] {
        IB_CLASS_ALU   = 2'd0,
        IB_CLASS_LOAD  = 2'd1,
        IB_CLASS_STORE = 2'd2
    } ib_class_e;

endpackage

//--- hw/ib_defines.svh
`ifndef IB_DEFINES_SVH
`define IB_DEFINES_SVH

// --------------------------------------------------
// Core dimensions
// --------------------------------------------------

// Hardware threads
`define IB_THREAD_NUM   2

// Dispatch slots per cycle, also push lanes per queue
`define IB_DISP_NUM     2

// Execution classes, one queue each
`define IB_CLASS_NUM    3

// Pop lanes per queue, same as FU ports per class
`define IB_ISSUE_NUM    2

// --------------------------------------------------
// Storage
// --------------------------------------------------

// Default instruction queue depth
`define IB_Q_SIZE       8

// Reorder tag width
`define IB_TAG_WIDTH    6

`endif
